/* include/cp0_defines.svh */
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// Register number and select, packed as {reg[4:0], sel[2:0]}
`define CP0_INDEX     {5'd0, 3'd0}
`define CP0_ENTRYLO0  {5'd2, 3'd0}
`define CP0_ENTRYLO1  {5'd3, 3'd0}
`define CP0_BADVADDR  {5'd8, 3'd0}
`define CP0_COUNT     {5'd9, 3'd0}
`define CP0_ENTRYHI   {5'd10, 3'd0}
`define CP0_COMPARE   {5'd11, 3'd0}
`define CP0_STATUS    {5'd12, 3'd0}
`define CP0_CAUSE     {5'd13, 3'd0}
`define CP0_EPC       {5'd14, 3'd0}
`define CP0_PRID      {5'd15, 3'd0}
`define CP0_EBASE     {5'd15, 3'd1}
`define CP0_CONFIG    {5'd16, 3'd0}
`define CP0_CONFIG1   {5'd16, 3'd1}

`define CP0_STATUS_RESET     32'h1040_0000  // CU0 and BEV set
`define CP0_EBASE_RESET      32'h8000_0000

`define BOOT_VEC_BASE        32'hBFC0_0200
`define VEC_GENERAL_OFF      32'h0000_0180
`define VEC_SPECIAL_INT_OFF  32'h0000_0200

`define EXC_INT              5'd0

`define TLB_ENTRIES          16

`endif

/* hdl/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] cp0_word_t;   // CP0 data word
    typedef logic [7:0]  cp0_addr_t;   // {reg, sel}
    typedef logic [4:0]  exc_code_t;   // Cause ExcCode
    typedef logic [5:0]  hw_int_t;     // Hardware interrupt lines

    typedef logic [18:0] vpn2_t;       // Virtual page pair number
    typedef logic [23:0] pfn_t;        // Physical frame number

    // {vpn2, pfn1, d/v1, pfn0, d/v0, index}
    typedef logic [74:0] tlb_cfg_t;

    typedef logic [31:0] paddr_t;

endpackage

`default_nettype wire

/* hdl/cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defines.svh"

module cp0_regs (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire cp0_pkg::cp0_addr_t rd_addr_i,
    input  wire                     we_i,
    input  wire cp0_pkg::cp0_addr_t wr_addr_i,
    input  wire cp0_pkg::cp0_word_t data_i,
    input  wire cp0_pkg::hw_int_t   ip_hw_i,
    input  wire                     en_exp_i,
    input  wire cp0_pkg::exc_code_t exc_code_i,
    input  wire cp0_pkg::cp0_word_t exc_epc_i,
    input  wire                     exc_bd_i,
    input  wire cp0_pkg::cp0_word_t exc_bad_vaddr_i,
    input  wire                     clean_exl_i,
    input  wire cp0_pkg::cp0_addr_t dbg_rd_addr_i,
    output cp0_pkg::cp0_word_t      data_o,
    output cp0_pkg::cp0_word_t      dbg_data_o,
    output logic                    timer_int_o,
    output logic                    user_mode_o,
    output logic                    allow_int_o,
    output logic [7:0]              interrupt_mask_o,
    output logic [1:0]              software_int_o,
    output logic [19:0]             ebase_o,
    output logic                    special_int_vec_o,
    output logic                    boot_exp_vec_o,
    output cp0_pkg::tlb_cfg_t       tlb_config_o
);

    localparam cp0_pkg::cp0_word_t status_reset  = `CP0_STATUS_RESET;
    localparam cp0_pkg::cp0_word_t ebase_reset   = `CP0_EBASE_RESET;
    localparam cp0_pkg::cp0_word_t prid_value    = 32'h0001_8000;  // 4Kc core id
    localparam cp0_pkg::cp0_word_t config1_value = {1'b0, 6'(`TLB_ENTRIES - 1), 25'd0};

    cp0_pkg::cp0_word_t status_q;
    cp0_pkg::cp0_word_t count_q;
    cp0_pkg::cp0_word_t compare_q;
    cp0_pkg::cp0_word_t epc_q;
    cp0_pkg::cp0_word_t bad_vaddr_q;
    logic [17:0]        ebase_q;      // EBase[29:12]

    logic               cause_bd_q;
    logic               cause_iv_q;
    logic [1:0]         cause_sw_q;
    cp0_pkg::exc_code_t cause_exc_q;

    cp0_pkg::vpn2_t     entry_hi_q;
    cp0_pkg::pfn_t      lo0_pfn_q;
    cp0_pkg::pfn_t      lo1_pfn_q;
    logic [1:0]         lo0_dv_q;     // {D, V}
    logic [1:0]         lo1_dv_q;
    logic [3:0]         index_q;
    logic [2:0]         config_k0_q;

    // Both read ports decode through the same mux
    function automatic cp0_pkg::cp0_word_t read_reg(input cp0_pkg::cp0_addr_t addr);
        cp0_pkg::cp0_word_t value;
        case (addr)
            `CP0_INDEX:    value = {28'd0, index_q};
            `CP0_ENTRYLO0: value = {2'b00, lo0_pfn_q, 3'b000, lo0_dv_q, 1'b0};
            `CP0_ENTRYLO1: value = {2'b00, lo1_pfn_q, 3'b000, lo1_dv_q, 1'b0};
            `CP0_BADVADDR: value = bad_vaddr_q;
            `CP0_COUNT:    value = count_q;
            `CP0_ENTRYHI:  value = {entry_hi_q, 13'd0};
            `CP0_COMPARE:  value = compare_q;
            `CP0_STATUS:   value = status_q;
            `CP0_CAUSE: begin
                value = {cause_bd_q, 7'd0, cause_iv_q, 7'd0, ip_hw_i, cause_sw_q,
                         1'b0, cause_exc_q, 2'b00};
            end
            `CP0_EPC:      value = epc_q;
            `CP0_PRID:     value = prid_value;
            `CP0_EBASE:    value = {ebase_reset[31:30], ebase_q, 12'd0};
            `CP0_CONFIG:   value = {1'b1, 21'd0, 3'd1, 4'd0, config_k0_q};  // Release 1 MMU
            `CP0_CONFIG1:  value = config1_value;
            default:       value = '0;
        endcase
        return value;
    endfunction

    always_comb begin
        data_o = read_reg(rd_addr_i);
    end

    always_comb begin
        dbg_data_o = read_reg(dbg_rd_addr_i);
    end

    assign user_mode_o       = !status_q[1] && status_q[4];
    assign allow_int_o       = !status_q[1] && status_q[0];
    assign interrupt_mask_o  = status_q[15:8];
    assign boot_exp_vec_o    = status_q[22];
    assign software_int_o    = cause_sw_q;
    assign special_int_vec_o = cause_iv_q;
    assign ebase_o           = {ebase_reset[31:30], ebase_q};

    assign tlb_config_o = {entry_hi_q, lo1_pfn_q, lo1_dv_q, lo0_pfn_q, lo0_dv_q, index_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q    <= status_reset;
            count_q     <= '0;
            compare_q   <= '0;
            ebase_q     <= ebase_reset[29:12];
            cause_sw_q  <= '0;
            cause_iv_q  <= 1'b0;
            timer_int_o <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != '0 && compare_q == count_q) begin
                timer_int_o <= 1'b1;
            end
            if (we_i) begin
                case (wr_addr_i)
                    `CP0_COUNT: count_q <= data_i;
                    `CP0_COMPARE: begin
                        compare_q   <= data_i;
                        timer_int_o <= 1'b0;  // Compare write acks the timer
                    end
                    `CP0_STATUS: begin
                        status_q[22]   <= data_i[22];   // BEV
                        status_q[15:8] <= data_i[15:8]; // IM
                        status_q[4]    <= data_i[4];    // UM
                        status_q[2:0]  <= data_i[2:0];  // ERL, EXL, IE
                    end
                    `CP0_CAUSE: begin
                        cause_sw_q <= data_i[9:8];
                        cause_iv_q <= data_i[23];
                    end
                    `CP0_EBASE: ebase_q <= data_i[29:12];
                    default: ;
                endcase
            end
            if (en_exp_i) begin
                status_q[1] <= 1'b1;
            end else if (clean_exl_i) begin
                status_q[1] <= 1'b0;      // ERET
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            case (wr_addr_i)
                `CP0_EPC:     epc_q <= data_i;
                `CP0_ENTRYHI: entry_hi_q <= data_i[31:13];
                `CP0_ENTRYLO0: begin
                    lo0_pfn_q <= data_i[29:6];
                    lo0_dv_q  <= data_i[2:1];
                end
                `CP0_ENTRYLO1: begin
                    lo1_pfn_q <= data_i[29:6];
                    lo1_dv_q  <= data_i[2:1];
                end
                `CP0_INDEX:   index_q <= data_i[3:0];
                `CP0_CONFIG:  config_k0_q <= data_i[2:0];
                default: ;
            endcase
        end
        if (en_exp_i) begin
            epc_q       <= exc_epc_i;     // Commit wins over a software write
            bad_vaddr_q <= exc_bad_vaddr_i;
            cause_bd_q  <= exc_bd_i;
            cause_exc_q <= exc_code_i;
        end
    end

    // Commit and ERET come from the exception unit and must be exclusive
    assert property (@(posedge clk) disable iff (!rst_n) !(en_exp_i && clean_exl_i))
        else $error("cp0_regs: en_exp and clean_exl high in the same cycle");

endmodule

`default_nettype wire

/* hdl/exception_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defines.svh"

module exception_unit (
    input  wire cp0_pkg::hw_int_t   hw_int_i,
    input  wire                     timer_int_i,
    input  wire                     allow_int_i,
    input  wire [7:0]               interrupt_mask_i,
    input  wire [1:0]               software_int_i,
    input  wire [19:0]              ebase_i,
    input  wire                     special_int_vec_i,
    input  wire                     boot_exp_vec_i,
    input  wire                     exc_req_i,
    input  wire cp0_pkg::exc_code_t exc_code_i,
    input  wire                     eret_i,
    output cp0_pkg::hw_int_t        ip_hw_o,
    output logic                    en_exp_o,
    output cp0_pkg::exc_code_t      exc_code_o,
    output logic                    clean_exl_o,
    output logic                    exc_taken_o,
    output cp0_pkg::cp0_word_t      exc_vector_o
);

    cp0_pkg::hw_int_t   ip_merged;
    logic [7:0]         ip_masked;
    logic               int_pending;
    cp0_pkg::cp0_word_t ebase_addr;

    // Timer shares hardware line 5
    assign ip_merged = {hw_int_i[5] | timer_int_i, hw_int_i[4:0]};
    assign ip_hw_o   = ip_merged;

    assign ip_masked   = {ip_merged, software_int_i} & interrupt_mask_i;
    assign int_pending = allow_int_i && (ip_masked != 8'd0);

    // Pending interrupt outranks a synchronous request
    assign exc_taken_o = int_pending || exc_req_i;
    assign en_exp_o    = exc_taken_o;
    assign exc_code_o  = int_pending ? `EXC_INT : exc_code_i;
    assign clean_exl_o = eret_i && !int_pending;

    assign ebase_addr = {ebase_i, 12'd0};

    always_comb begin
        if (boot_exp_vec_i) begin
            exc_vector_o = `BOOT_VEC_BASE + `VEC_GENERAL_OFF;
        end else if (int_pending && special_int_vec_i) begin
            exc_vector_o = ebase_addr + `VEC_SPECIAL_INT_OFF;  // IV set
        end else begin
            exc_vector_o = ebase_addr + `VEC_GENERAL_OFF;
        end
    end

    always_comb begin
        assert final (!(exc_req_i && eret_i))
            else $error("exception_unit: exc_req and eret in the same cycle");
    end

endmodule

`default_nettype wire

/* hdl/tlb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defines.svh"

module tlb (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     tlbwi_i,
    input  wire cp0_pkg::tlb_cfg_t  tlb_config_i,
    input  wire cp0_pkg::cp0_word_t vaddr_i,
    output cp0_pkg::paddr_t         paddr_o,
    output logic                    hit_o,
    output logic                    dirty_o
);

    cp0_pkg::vpn2_t          vpn2_q [`TLB_ENTRIES];
    cp0_pkg::pfn_t           pfn0_q [`TLB_ENTRIES];
    cp0_pkg::pfn_t           pfn1_q [`TLB_ENTRIES];
    logic [1:0]              dv0_q  [`TLB_ENTRIES];   // {D, V}
    logic [1:0]              dv1_q  [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] valid_q;
    logic [`TLB_ENTRIES-1:0] match;

    cp0_pkg::vpn2_t          wr_vpn2;
    cp0_pkg::pfn_t           wr_pfn1;
    logic [1:0]              wr_dv1;
    cp0_pkg::pfn_t           wr_pfn0;
    logic [1:0]              wr_dv0;
    logic [3:0]              wr_index;

    assign {wr_vpn2, wr_pfn1, wr_dv1, wr_pfn0, wr_dv0, wr_index} = tlb_config_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tlbwi_i) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbwi_i) begin
            vpn2_q[wr_index] <= wr_vpn2;
            pfn0_q[wr_index] <= wr_pfn0;
            pfn1_q[wr_index] <= wr_pfn1;
            dv0_q[wr_index]  <= wr_dv0;
            dv1_q[wr_index]  <= wr_dv1;
        end
    end

    always_comb begin
        cp0_pkg::pfn_t page_pfn;
        logic [1:0]    page_dv;
        page_pfn = '0;
        page_dv  = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = valid_q[i] && (vpn2_q[i] == vaddr_i[31:13]);
            if (match[i]) begin
                page_pfn = vaddr_i[12] ? pfn1_q[i] : pfn0_q[i];  // Odd or even page
                page_dv  = vaddr_i[12] ? dv1_q[i] : dv0_q[i];
            end
        end
        paddr_o = {page_pfn[19:0], vaddr_i[11:0]};
        hit_o   = (match != '0) && page_dv[0];
        dirty_o = hit_o && page_dv[1];
    end

    // Software must not load overlapping entries
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match))
        else $error("tlb: more than one entry matches the virtual address");

endmodule

`default_nettype wire

/* hdl/cp0_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_subsystem (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire cp0_pkg::cp0_addr_t rd_addr_i,
    output cp0_pkg::cp0_word_t      data_o,
    input  wire                     we_i,
    input  wire cp0_pkg::cp0_addr_t wr_addr_i,
    input  wire cp0_pkg::cp0_word_t data_i,
    input  wire cp0_pkg::hw_int_t   hw_int_i,
    input  wire                     exc_req_i,
    input  wire cp0_pkg::exc_code_t exc_code_i,
    input  wire cp0_pkg::cp0_word_t exc_epc_i,
    input  wire                     exc_bd_i,
    input  wire cp0_pkg::cp0_word_t exc_bad_vaddr_i,
    input  wire                     eret_i,
    input  wire                     tlbwi_i,
    input  wire cp0_pkg::cp0_word_t vaddr_i,
    output cp0_pkg::paddr_t         paddr_o,
    output logic                    tlb_hit_o,
    output logic                    tlb_dirty_o,
    input  wire cp0_pkg::cp0_addr_t dbg_rd_addr_i,
    output cp0_pkg::cp0_word_t      dbg_data_o,
    output logic                    exc_taken_o,
    output cp0_pkg::cp0_word_t      exc_vector_o,
    output logic                    timer_int_o,
    output logic                    user_mode_o
);

    cp0_pkg::hw_int_t   ip_hw;
    logic               en_exp;
    cp0_pkg::exc_code_t exc_code;     // After interrupt substitution
    logic               clean_exl;
    logic               allow_int;
    logic [7:0]         interrupt_mask;
    logic [1:0]         software_int;
    logic [19:0]        ebase;
    logic               special_int_vec;
    logic               boot_exp_vec;
    cp0_pkg::tlb_cfg_t  tlb_config;

    cp0_regs u_cp0_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_addr_i         (rd_addr_i),
        .we_i              (we_i),
        .wr_addr_i         (wr_addr_i),
        .data_i            (data_i),
        .ip_hw_i           (ip_hw),
        .en_exp_i          (en_exp),
        .exc_code_i        (exc_code),
        .exc_epc_i         (exc_epc_i),
        .exc_bd_i          (exc_bd_i),
        .exc_bad_vaddr_i   (exc_bad_vaddr_i),
        .clean_exl_i       (clean_exl),
        .dbg_rd_addr_i     (dbg_rd_addr_i),
        .data_o            (data_o),
        .dbg_data_o        (dbg_data_o),
        .timer_int_o       (timer_int_o),
        .user_mode_o       (user_mode_o),
        .allow_int_o       (allow_int),
        .interrupt_mask_o  (interrupt_mask),
        .software_int_o    (software_int),
        .ebase_o           (ebase),
        .special_int_vec_o (special_int_vec),
        .boot_exp_vec_o    (boot_exp_vec),
        .tlb_config_o      (tlb_config)
    );

    exception_unit u_exception_unit (
        .hw_int_i          (hw_int_i),
        .timer_int_i       (timer_int_o),
        .allow_int_i       (allow_int),
        .interrupt_mask_i  (interrupt_mask),
        .software_int_i    (software_int),
        .ebase_i           (ebase),
        .special_int_vec_i (special_int_vec),
        .boot_exp_vec_i    (boot_exp_vec),
        .exc_req_i         (exc_req_i),
        .exc_code_i        (exc_code_i),
        .eret_i            (eret_i),
        .ip_hw_o           (ip_hw),
        .en_exp_o          (en_exp),
        .exc_code_o        (exc_code),
        .clean_exl_o       (clean_exl),
        .exc_taken_o       (exc_taken_o),
        .exc_vector_o      (exc_vector_o)
    );

    tlb u_tlb (
        .clk               (clk),
        .rst_n             (rst_n),
        .tlbwi_i           (tlbwi_i),
        .tlb_config_i      (tlb_config),
        .vaddr_i           (vaddr_i),
        .paddr_o           (paddr_o),
        .hit_o             (tlb_hit_o),
        .dirty_o           (tlb_dirty_o)
    );

endmodule

`default_nettype wire

/* tb/tb_cp0_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defines.svh"

module tb_cp0_subsystem;

    localparam int clk_period = 40;
    localparam int max_rows   = 64;

    localparam cp0_pkg::cp0_word_t status_wmask  = 32'h0040_FF17;  // BEV, IM, UM, ERL, EXL, IE
    localparam cp0_pkg::cp0_word_t entrylo_wmask = 32'h3FFF_FFC6;  // PFN, D, V
    localparam cp0_pkg::cp0_word_t index_wmask   = 32'h0000_000F;
    localparam cp0_pkg::cp0_word_t all_bits      = 32'hFFFF_FFFF;

    localparam cp0_pkg::cp0_addr_t sig_timer = 8'd0;  // Selects for bit checks
    localparam cp0_pkg::cp0_addr_t sig_umode = 8'd1;
    localparam cp0_pkg::cp0_addr_t sig_taken = 8'd2;

    typedef enum logic [3:0] {
        op_write, op_read, op_dbg_read, op_exc, op_eret, op_tlbwi, op_xlate, op_int, op_hw, op_bit
    } op_t;

    logic               clk;
    logic               rst_n;
    cp0_pkg::cp0_addr_t rd_addr_i;
    cp0_pkg::cp0_word_t data_o;
    logic               we_i;
    cp0_pkg::cp0_addr_t wr_addr_i;
    cp0_pkg::cp0_word_t data_i;
    cp0_pkg::hw_int_t   hw_int_i;
    logic               exc_req_i;
    cp0_pkg::exc_code_t exc_code_i;
    cp0_pkg::cp0_word_t exc_epc_i;
    logic               exc_bd_i;
    cp0_pkg::cp0_word_t exc_bad_vaddr_i;
    logic               eret_i;
    logic               tlbwi_i;
    cp0_pkg::cp0_word_t vaddr_i;
    cp0_pkg::paddr_t    paddr_o;
    logic               tlb_hit_o;
    logic               tlb_dirty_o;
    cp0_pkg::cp0_addr_t dbg_rd_addr_i;
    cp0_pkg::cp0_word_t dbg_data_o;
    logic               exc_taken_o;
    cp0_pkg::cp0_word_t exc_vector_o;
    logic               timer_int_o;
    logic               user_mode_o;

    op_t                row_op   [max_rows];
    string              row_name [max_rows];
    cp0_pkg::cp0_addr_t row_addr [max_rows];
    cp0_pkg::cp0_word_t row_data [max_rows];
    cp0_pkg::cp0_word_t row_aux  [max_rows];  // Read mask, BadVAddr or {dirty, hit}
    cp0_pkg::cp0_word_t row_exp  [max_rows];
    int                 row_count;
    logic               table_ready;
    int                 value_errors;
    int                 other_errors;
    integer             seed;

    cp0_subsystem DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_addr_i       (rd_addr_i),
        .data_o          (data_o),
        .we_i            (we_i),
        .wr_addr_i       (wr_addr_i),
        .data_i          (data_i),
        .hw_int_i        (hw_int_i),
        .exc_req_i       (exc_req_i),
        .exc_code_i      (exc_code_i),
        .exc_epc_i       (exc_epc_i),
        .exc_bd_i        (exc_bd_i),
        .exc_bad_vaddr_i (exc_bad_vaddr_i),
        .eret_i          (eret_i),
        .tlbwi_i         (tlbwi_i),
        .vaddr_i         (vaddr_i),
        .paddr_o         (paddr_o),
        .tlb_hit_o       (tlb_hit_o),
        .tlb_dirty_o     (tlb_dirty_o),
        .dbg_rd_addr_i   (dbg_rd_addr_i),
        .dbg_data_o      (dbg_data_o),
        .exc_taken_o     (exc_taken_o),
        .exc_vector_o    (exc_vector_o),
        .timer_int_o     (timer_int_o),
        .user_mode_o     (user_mode_o)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_word(input string name, input cp0_pkg::cp0_word_t exp,
                              input cp0_pkg::cp0_word_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_paddr(input string name, input cp0_pkg::paddr_t exp,
                               input cp0_pkg::paddr_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // EntryLo layout: PFN in 29:6, D in bit 2, V in bit 1
    function automatic cp0_pkg::cp0_word_t entrylo_word(input cp0_pkg::pfn_t pfn,
                                                        input logic d, input logic v);
        return {2'b00, pfn, 3'b000, d, v, 1'b0};
    endfunction

    function automatic logic watched_bit(input cp0_pkg::cp0_addr_t sel);
        case (sel)
            sig_timer: return timer_int_o;
            sig_umode: return user_mode_o;
            default:   return exc_taken_o;
        endcase
    endfunction

    task automatic add_row(input op_t op, input string name, input cp0_pkg::cp0_addr_t addr,
                           input cp0_pkg::cp0_word_t data, input cp0_pkg::cp0_word_t aux,
                           input cp0_pkg::cp0_word_t exp);
        row_op[row_count]   = op;
        row_name[row_count] = name;
        row_addr[row_count] = addr;
        row_data[row_count] = data;
        row_aux[row_count]  = aux;
        row_exp[row_count]  = exp;
        row_count++;
    endtask

    task automatic build_table();
        cp0_pkg::cp0_word_t r_status;
        cp0_pkg::cp0_word_t r_lo0;
        cp0_pkg::cp0_word_t r_index;
        cp0_pkg::cp0_word_t status_ref;
        cp0_pkg::cp0_word_t epc;
        cp0_pkg::cp0_word_t bad_va;
        cp0_pkg::cp0_word_t ebase;
        r_status   = $random(seed);
        r_lo0      = $random(seed);
        r_index    = $random(seed);
        status_ref = (`CP0_STATUS_RESET & ~status_wmask) | (r_status & status_wmask);
        epc        = 32'h8000_1234;
        bad_va     = 32'h0000_0ABD;
        ebase      = 32'h8000_3000;

        add_row(op_bit, "reset_taken", sig_taken, 0, 0, 0);
        add_row(op_bit, "reset_timer", sig_timer, 0, 0, 0);
        add_row(op_read, "reset_status", `CP0_STATUS, 0, all_bits, `CP0_STATUS_RESET);
        add_row(op_dbg_read, "reset_prid", `CP0_PRID, 0, all_bits, 32'h0001_8000);
        add_row(op_read, "reset_ebase", `CP0_EBASE, 0, all_bits, `CP0_EBASE_RESET);
        add_row(op_write, "wr_status_rand", `CP0_STATUS, r_status, 0, 0);
        add_row(op_read, "mask_status", `CP0_STATUS, 0, all_bits, status_ref);
        add_row(op_dbg_read, "mask_status_dbg", `CP0_STATUS, 0, all_bits, status_ref);
        add_row(op_write, "wr_lo0_rand", `CP0_ENTRYLO0, r_lo0, 0, 0);
        add_row(op_read, "mask_lo0", `CP0_ENTRYLO0, 0, all_bits, r_lo0 & entrylo_wmask);
        add_row(op_dbg_read, "mask_lo0_dbg", `CP0_ENTRYLO0, 0, all_bits, r_lo0 & entrylo_wmask);
        add_row(op_write, "wr_index_rand", `CP0_INDEX, r_index, 0, 0);
        add_row(op_read, "mask_index", `CP0_INDEX, 0, all_bits, r_index & index_wmask);
        add_row(op_dbg_read, "mask_index_dbg", `CP0_INDEX, 0, all_bits, r_index & index_wmask);
        add_row(op_write, "restore_status", `CP0_STATUS, `CP0_STATUS_RESET, 0, 0);

        add_row(op_write, "timer_count", `CP0_COUNT, 0, 0, 0);
        add_row(op_write, "timer_compare", `CP0_COMPARE, 20, 0, 0);
        add_row(op_bit, "timer_rise", sig_timer, 30, 0, 1);
        add_row(op_write, "timer_ack", `CP0_COMPARE, 0, 0, 0);
        add_row(op_bit, "timer_cleared", sig_timer, 0, 0, 0);

        add_row(op_write, "exc_user", `CP0_STATUS, 32'h1040_0010, 0, 0);
        add_row(op_bit, "exc_umode_before", sig_umode, 0, 0, 1);
        add_row(op_exc, "exc_boot_vector", 8'd4, epc, bad_va,
                `BOOT_VEC_BASE + `VEC_GENERAL_OFF);
        add_row(op_bit, "exc_strobe_low", sig_taken, 0, 0, 0);
        add_row(op_read, "exc_epc", `CP0_EPC, 0, all_bits, epc);
        add_row(op_read, "exc_badvaddr", `CP0_BADVADDR, 0, all_bits, bad_va);
        add_row(op_read, "exc_cause_code", `CP0_CAUSE, 0, 32'h0000_007C, 32'd4 << 2);
        add_row(op_read, "exc_exl_set", `CP0_STATUS, 0, 32'h0000_0002, 32'h0000_0002);
        add_row(op_bit, "exc_umode_after", sig_umode, 0, 0, 0);

        add_row(op_eret, "eret", 0, 0, 0, 0);
        add_row(op_read, "eret_exl_clear", `CP0_STATUS, 0, 32'h0000_0002, 0);
        add_row(op_bit, "eret_umode", sig_umode, 0, 0, 1);

        add_row(op_write, "int_ebase", `CP0_EBASE, ebase, 0, 0);
        add_row(op_read, "int_ebase_rd", `CP0_EBASE, 0, all_bits, ebase);
        add_row(op_write, "int_cause_iv", `CP0_CAUSE, 32'h0080_0000, 0, 0);
        add_row(op_write, "int_status", `CP0_STATUS, 32'h1000_1001, 0, 0);  // IM for line 2, IE
        add_row(op_read, "int_status_rd", `CP0_STATUS, 0, all_bits, 32'h1000_1001);
        add_row(op_int, "int_vector", 0, 32'h0000_0004, 0, ebase + `VEC_SPECIAL_INT_OFF);
        add_row(op_bit, "int_taken_once", sig_taken, 0, 0, 0);
        add_row(op_read, "int_cause", `CP0_CAUSE, 0, 32'h0080_FC7C, 32'h0080_1000);
        add_row(op_hw, "int_release", 0, 0, 0, 0);
        add_row(op_read, "int_exl_set", `CP0_STATUS, 0, 32'h0000_0002, 32'h0000_0002);

        add_row(op_write, "tlb_entryhi", `CP0_ENTRYHI, 32'h2468_A000, 0, 0);
        add_row(op_write, "tlb_lo0", `CP0_ENTRYLO0, entrylo_word(24'h000ABC, 1'b1, 1'b1), 0, 0);
        add_row(op_write, "tlb_lo1", `CP0_ENTRYLO1, entrylo_word(24'h000DEF, 1'b0, 1'b1), 0, 0);
        add_row(op_write, "tlb_index", `CP0_INDEX, 32'd5, 0, 0);
        add_row(op_xlate, "tlb_before_wi", 0, 32'h2468_A123, 32'd0, 0);
        add_row(op_tlbwi, "tlbwi", 0, 0, 0, 0);
        add_row(op_xlate, "tlb_even", 0, 32'h2468_A123, 32'd3, 32'h00AB_C123);
        add_row(op_xlate, "tlb_odd", 0, 32'h2468_B456, 32'd1, 32'h00DE_F456);
        add_row(op_xlate, "tlb_miss", 0, 32'h1000_0000, 32'd0, 0);
    endtask

    task automatic apply_row(input int i);
        logic bit_now;
        int   waited;
        @(posedge clk);
        #1;
        we_i      = 1'b0;
        exc_req_i = 1'b0;
        eret_i    = 1'b0;
        tlbwi_i   = 1'b0;
        case (row_op[i])
            op_write: begin
                we_i      = 1'b1;
                wr_addr_i = row_addr[i];
                data_i    = row_data[i];
            end
            op_read:     rd_addr_i = row_addr[i];
            op_dbg_read: dbg_rd_addr_i = row_addr[i];
            op_exc: begin
                exc_req_i       = 1'b1;
                exc_code_i      = row_addr[i][4:0];
                exc_epc_i       = row_data[i];
                exc_bad_vaddr_i = row_aux[i];
            end
            op_eret:       eret_i = 1'b1;
            op_tlbwi:      tlbwi_i = 1'b1;
            op_xlate:      vaddr_i = row_data[i];
            op_int, op_hw: hw_int_i = row_data[i][5:0];  // Level, held until changed
            default: ;
        endcase
        @(negedge clk);
        case (row_op[i])
            op_read:     check_word(row_name[i], row_exp[i], data_o & row_aux[i]);
            op_dbg_read: check_word(row_name[i], row_exp[i], dbg_data_o & row_aux[i]);
            op_exc, op_int: begin
                check_bit(row_name[i], 1'b1, exc_taken_o);
                check_word(row_name[i], row_exp[i], exc_vector_o);
            end
            op_xlate: begin
                check_bit(row_name[i], row_aux[i][0], tlb_hit_o);
                check_bit(row_name[i], row_aux[i][1], tlb_dirty_o);
                if (row_aux[i][0]) begin
                    check_paddr(row_name[i], row_exp[i], paddr_o);
                end
            end
            op_bit: begin
                waited  = 0;
                bit_now = watched_bit(row_addr[i]);
                while (bit_now !== row_exp[i][0] && waited < int'(row_data[i])) begin
                    @(negedge clk);
                    waited++;
                    bit_now = watched_bit(row_addr[i]);
                end
                if (row_data[i] == 0) begin
                    check_bit(row_name[i], row_exp[i][0], bit_now);
                end else if (bit_now !== row_exp[i][0]) begin
                    $display("%s: signal did not reach %0b within %0d cycles",
                             row_name[i], row_exp[i][0], row_data[i]);
                    other_errors++;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        wait (table_ready);
        #((row_count + 200) * clk_period);
        $display("Watchdog timeout: the test sequence did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        rd_addr_i       = '0;
        we_i            = 1'b0;
        wr_addr_i       = '0;
        data_i          = '0;
        hw_int_i        = '0;
        exc_req_i       = 1'b0;
        exc_code_i      = '0;
        exc_epc_i       = '0;
        exc_bd_i        = 1'b0;
        exc_bad_vaddr_i = '0;
        eret_i          = 1'b0;
        tlbwi_i         = 1'b0;
        vaddr_i         = '0;
        dbg_rd_addr_i   = '0;
        seed            = 74254;
        row_count       = 0;
        value_errors    = 0;
        other_errors    = 0;
        table_ready     = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < row_count; i++) begin
            apply_row(i);
        end
        @(posedge clk);
        $display("Summary: %0d rows, %0d value errors, %0d other errors",
                 row_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hdl/cp0_pkg.sv
hdl/cp0_regs.sv
hdl/exception_unit.sv
hdl/tlb.sv
hdl/cp0_subsystem.sv
tb/tb_cp0_subsystem.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cp0_subsystem
RTL_TOP    := cp0_subsystem
FILELIST   := project.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
